//--- hw/motion_pkg.sv
package motion_pkg;

  // Microstep phase position, one count per step, wraps at 256
  typedef logic [7:0] phase_t;

  // Full-step quadrant taken from the top two phase bits
  typedef enum logic [1:0] {
    quad_0 = 2'd0,
    quad_1 = 2'd1,
    quad_2 = 2'd2,
    quad_3 = 2'd3
  } quadrant_e;

  // Winding labels for the two chopper channels
  typedef enum logic {
    winding_a = 1'b0,
    winding_b = 1'b1
  } winding_e;

  // Quadrant of a phase position
  function automatic quadrant_e quadrant_of(input phase_t phase);
    quadrant_e quad;
    quad = quadrant_e'(phase[7:6]);
    return quad;
  endfunction

endpackage

//--- hw/bridge_pkg.sv
package bridge_pkg;

  // Chopper cycle: blanked on-time, watched on-time, then fixed off-time
  typedef enum logic [1:0] {
    chop_blank = 2'd0,
    chop_on    = 2'd1,
    chop_off   = 2'd2
  } chop_state_e;

  // Decay applied to a winding during off-time
  typedef enum logic [1:0] {
    decay_none = 2'd0,
    decay_fast = 2'd1,
    decay_slow = 2'd2
  } decay_e;

  // Off timer, counts down through the off-time
  typedef logic [9:0] off_count_t;

  // Blank and minimum-on timers
  typedef logic [7:0] short_count_t;

  // Fast decay covers the early part of off-time, while the
  // count is still at or above the threshold
  function automatic decay_e decay_of(input chop_state_e state,
                                      input off_count_t  off_count,
                                      input off_count_t  threshold);
    decay_e mode;
    if (state != chop_off) begin
      mode = decay_none;
    end else if (off_count >= threshold) begin
      mode = decay_fast;
    end else begin
      mode = decay_slow;
    end
    return mode;
  endfunction

endpackage

//--- hw/stepper_ifs.sv
// Winding polarity strobes and the synchronized enable
interface phase_if;
  logic s1;
  logic s2;
  logic s3;
  logic s4;
  logic enable;

  modport source (
    output s1,
    output s2,
    output s3,
    output s4,
    output enable
  );

  modport sink (
    input s1,
    input s2,
    input s3,
    input s4,
    input enable
  );

  // Choppers only care whether the bridge is enabled
  modport mon (
    input enable
  );
endinterface

// State of one winding's chopper as seen by the bridge
interface chopper_if;
  bridge_pkg::chop_state_e state;
  bridge_pkg::off_count_t  off_count;
  logic                    fault_pulse;

  modport timer (
    output state,
    output off_count,
    output fault_pulse
  );

  modport drive (
    input state,
    input off_count,
    input fault_pulse
  );
endinterface

//--- hw/step_dir_decode.sv
module step_dir_decode (
  input  logic               clk,
  input  logic               resetn,
  input  logic               step,
  input  logic               dir,
  input  logic               enable_in,
  output motion_pkg::phase_t phase_ct,
  phase_if.source            ph
);

  logic [1:0] step_sync;
  logic       step_prev;
  logic [1:0] dir_sync;
  logic [1:0] enable_sync;
  logic       step_rise;
  logic       pol_a;
  logic       pol_b;

  motion_pkg::quadrant_e quadrant;

  // Two-flop synchronizers, plus one more stage on step for edge detect
  always_ff @(posedge clk) begin
    if (!resetn) begin
      step_sync   <= '0;
      step_prev   <= 1'b0;
      dir_sync    <= '0;
      enable_sync <= '0;
    end else begin
      step_sync   <= {step_sync[0], step};
      step_prev   <= step_sync[1];
      dir_sync    <= {dir_sync[0], dir};
      enable_sync <= {enable_sync[0], enable_in};
    end
  end

  assign step_rise = step_sync[1] & ~step_prev;

  // Phase counter wraps in both directions
  always_ff @(posedge clk) begin
    if (!resetn) begin
      phase_ct <= '0;
    end else if (step_rise) begin
      if (dir_sync[1]) begin
        phase_ct <= phase_ct + 1'b1;
      end else begin
        phase_ct <= phase_ct - 1'b1;
      end
    end
  end

  assign quadrant = motion_pkg::quadrant_of(phase_ct);

  // Winding A leads winding B by one quadrant
  assign pol_a = (quadrant == motion_pkg::quad_0) || (quadrant == motion_pkg::quad_3);
  assign pol_b = (quadrant == motion_pkg::quad_0) || (quadrant == motion_pkg::quad_1);

  assign ph.s1     = pol_a;
  assign ph.s2     = ~pol_a;
  assign ph.s3     = pol_b;
  assign ph.s4     = ~pol_b;
  assign ph.enable = enable_sync[1];

  // Counter moves only in response to a synchronized step edge
  a_phase_only_on_step: assert property (
    @(posedge clk) disable iff (!resetn)
    $changed(phase_ct) |-> $past(step_rise)
  ) else $error("phase counter moved without a step edge");

endmodule

//--- hw/chopper_timer.sv
module chopper_timer #(
  parameter motion_pkg::winding_e WINDING = motion_pkg::winding_a,
  parameter int unsigned BLANK_TICKS  = 20,
  parameter int unsigned MIN_ON_TICKS = 40,
  parameter int unsigned OFF_TICKS    = 800
) (
  input  logic      clk,
  input  logic      resetn,
  input  logic      analog_cmp,
  phase_if.mon      ph,
  chopper_if.timer  chop
);

  // Blank counts down to zero, so it is loaded one short
  localparam bridge_pkg::short_count_t BLANK_RELOAD =
    bridge_pkg::short_count_t'(BLANK_TICKS - 1);
  localparam bridge_pkg::short_count_t MIN_ON_RELOAD =
    bridge_pkg::short_count_t'(MIN_ON_TICKS);
  localparam bridge_pkg::off_count_t OFF_RELOAD =
    bridge_pkg::off_count_t'(OFF_TICKS);

  bridge_pkg::chop_state_e  state;
  bridge_pkg::short_count_t blank_cnt;
  bridge_pkg::short_count_t min_on_cnt;
  bridge_pkg::off_count_t   off_cnt;

  logic cmp_q;
  logic min_on_running;
  logic trip;
  logic fault_q;

  // Comparator is asynchronous to the clock
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cmp_q <= 1'b0;
    end else begin
      cmp_q <= analog_cmp;
    end
  end

  assign min_on_running = (min_on_cnt != '0);

  // Peak current reached, only honoured once blanking is over
  assign trip = (state == bridge_pkg::chop_on) && cmp_q;

  always_ff @(posedge clk) begin
    if (!resetn || !ph.enable) begin
      state      <= bridge_pkg::chop_blank;
      blank_cnt  <= BLANK_RELOAD;
      min_on_cnt <= MIN_ON_RELOAD;
      off_cnt    <= '0;
      fault_q    <= 1'b0;
    end else begin
      // Tripping this early means the winding looks shorted
      fault_q <= trip && min_on_running;

      if (min_on_running && state != bridge_pkg::chop_off) begin
        min_on_cnt <= min_on_cnt - 1'b1;
      end

      case (state)
        bridge_pkg::chop_blank: begin
          if (blank_cnt == '0) begin
            state <= bridge_pkg::chop_on;
          end else begin
            blank_cnt <= blank_cnt - 1'b1;
          end
        end
        bridge_pkg::chop_on: begin
          if (cmp_q) begin
            state   <= bridge_pkg::chop_off;
            off_cnt <= OFF_RELOAD;
          end
        end
        bridge_pkg::chop_off: begin
          // Last off-time cycle, start a fresh on-time
          if (off_cnt == bridge_pkg::off_count_t'(1)) begin
            state      <= bridge_pkg::chop_blank;
            blank_cnt  <= BLANK_RELOAD;
            min_on_cnt <= MIN_ON_RELOAD;
            off_cnt    <= '0;
          end else begin
            off_cnt <= off_cnt - 1'b1;
          end
        end
        default: state <= bridge_pkg::chop_blank;
      endcase
    end
  end

  assign chop.state       = state;
  assign chop.off_count   = off_cnt;
  assign chop.fault_pulse = fault_q;

  // Every off-time must be followed by a blanked on-time
  a_off_then_blank: assert property (
    @(posedge clk) disable iff (!resetn)
    state == bridge_pkg::chop_off |=> state != bridge_pkg::chop_on
  ) else $error("winding %s skipped blanking after off-time",
                (WINDING == motion_pkg::winding_a) ? "A" : "B");

endmodule

//--- hw/bridge_driver.sv
module bridge_driver (
  input  logic                   clk,
  input  logic                   resetn,
  input  bridge_pkg::off_count_t config_fastdecay_threshold,
  input  logic                   config_invert_highside,
  input  logic                   config_invert_lowside,
  phase_if.sink                  ph,
  chopper_if.drive               chop_a,
  chopper_if.drive               chop_b,
  output logic                   phase_a1_h,
  output logic                   phase_a1_l,
  output logic                   phase_a2_h,
  output logic                   phase_a2_l,
  output logic                   phase_b1_h,
  output logic                   phase_b1_l,
  output logic                   phase_b2_h,
  output logic                   phase_b2_l,
  output logic                   faultn
);

  bridge_pkg::decay_e decay_a;
  bridge_pkg::decay_e decay_b;

  // Active-high gate drive, order a1, a2, b1, b2
  logic [3:0] gate_h;
  logic [3:0] gate_l;
  logic       shutdown;

  // High and low gate of one half-bridge, as {high, low}
  function automatic logic [1:0] gate_pair(input bridge_pkg::decay_e decay,
                                           input logic               pol,
                                           input logic               off);
    logic [1:0] hl;
    case (decay)
      bridge_pkg::decay_fast: hl = {~pol, pol};
      bridge_pkg::decay_slow: hl = 2'b01;
      default:                hl = {pol, ~pol};
    endcase
    // Brake on the low sides when shut down
    if (off) begin
      hl = 2'b01;
    end
    return hl;
  endfunction

  // Any chopper fault latches until reset
  always_ff @(posedge clk) begin
    if (!resetn) begin
      faultn <= 1'b1;
    end else if (chop_a.fault_pulse || chop_b.fault_pulse) begin
      faultn <= 1'b0;
    end
  end

  assign decay_a = bridge_pkg::decay_of(chop_a.state, chop_a.off_count,
                                        config_fastdecay_threshold);
  assign decay_b = bridge_pkg::decay_of(chop_b.state, chop_b.off_count,
                                        config_fastdecay_threshold);

  assign shutdown = ~ph.enable | ~faultn;

  assign {gate_h[0], gate_l[0]} = gate_pair(decay_a, ph.s1, shutdown);
  assign {gate_h[1], gate_l[1]} = gate_pair(decay_a, ph.s2, shutdown);
  assign {gate_h[2], gate_l[2]} = gate_pair(decay_b, ph.s3, shutdown);
  assign {gate_h[3], gate_l[3]} = gate_pair(decay_b, ph.s4, shutdown);

  // Pin polarity to match the external gate drivers
  assign phase_a1_h = gate_h[0] ^ config_invert_highside;
  assign phase_a2_h = gate_h[1] ^ config_invert_highside;
  assign phase_b1_h = gate_h[2] ^ config_invert_highside;
  assign phase_b2_h = gate_h[3] ^ config_invert_highside;

  assign phase_a1_l = gate_l[0] ^ config_invert_lowside;
  assign phase_a2_l = gate_l[1] ^ config_invert_lowside;
  assign phase_b1_l = gate_l[2] ^ config_invert_lowside;
  assign phase_b2_l = gate_l[3] ^ config_invert_lowside;

  // No shoot-through and no floating half-bridge in any chopper state
  a_one_side_per_bridge: assert property (
    @(posedge clk) disable iff (!resetn)
    (gate_h ^ gate_l) == 4'hf
  ) else $error("half-bridge gates not complementary: h=%b l=%b", gate_h, gate_l);

endmodule

//--- hw/microstepper_top.sv
module microstepper_top #(
  parameter int unsigned BLANK_TICKS  = 20,
  parameter int unsigned MIN_ON_TICKS = 40,
  parameter int unsigned OFF_TICKS    = 800
) (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   step,
  input  logic                   dir,
  input  logic                   enable_in,
  input  logic                   analog_cmp_a,
  input  logic                   analog_cmp_b,
  input  bridge_pkg::off_count_t config_fastdecay_threshold,
  input  logic                   config_invert_highside,
  input  logic                   config_invert_lowside,
  output logic                   phase_a1_h,
  output logic                   phase_a1_l,
  output logic                   phase_a2_h,
  output logic                   phase_a2_l,
  output logic                   phase_b1_h,
  output logic                   phase_b1_l,
  output logic                   phase_b2_h,
  output logic                   phase_b2_l,
  output logic                   faultn,
  output motion_pkg::phase_t     phase_ct
);

  phase_if   ph_bus ();
  chopper_if chop_a_bus ();
  chopper_if chop_b_bus ();

  step_dir_decode decode_i (
    .clk       (clk),
    .resetn    (resetn),
    .step      (step),
    .dir       (dir),
    .enable_in (enable_in),
    .phase_ct  (phase_ct),
    .ph        (ph_bus.source)
  );

  chopper_timer #(
    .WINDING      (motion_pkg::winding_a),
    .BLANK_TICKS  (BLANK_TICKS),
    .MIN_ON_TICKS (MIN_ON_TICKS),
    .OFF_TICKS    (OFF_TICKS)
  ) chopper_a_i (
    .clk        (clk),
    .resetn     (resetn),
    .analog_cmp (analog_cmp_a),
    .ph         (ph_bus.mon),
    .chop       (chop_a_bus.timer)
  );

  chopper_timer #(
    .WINDING      (motion_pkg::winding_b),
    .BLANK_TICKS  (BLANK_TICKS),
    .MIN_ON_TICKS (MIN_ON_TICKS),
    .OFF_TICKS    (OFF_TICKS)
  ) chopper_b_i (
    .clk        (clk),
    .resetn     (resetn),
    .analog_cmp (analog_cmp_b),
    .ph         (ph_bus.mon),
    .chop       (chop_b_bus.timer)
  );

  bridge_driver driver_i (
    .clk                        (clk),
    .resetn                     (resetn),
    .config_fastdecay_threshold (config_fastdecay_threshold),
    .config_invert_highside     (config_invert_highside),
    .config_invert_lowside      (config_invert_lowside),
    .ph                         (ph_bus.sink),
    .chop_a                     (chop_a_bus.drive),
    .chop_b                     (chop_b_bus.drive),
    .phase_a1_h                 (phase_a1_h),
    .phase_a1_l                 (phase_a1_l),
    .phase_a2_h                 (phase_a2_h),
    .phase_a2_l                 (phase_a2_l),
    .phase_b1_h                 (phase_b1_h),
    .phase_b1_l                 (phase_b1_l),
    .phase_b2_h                 (phase_b2_h),
    .phase_b2_l                 (phase_b2_l),
    .faultn                     (faultn)
  );

endmodule

//--- sim/tb_microstepper.sv
module tb_microstepper;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD  = 4;
  localparam int BLANK_TICKS = 20;
  localparam int OFF_TICKS   = 60;
  localparam int THRESHOLD   = 40;
  localparam int DECAY_NONE  = 0;
  localparam int DECAY_FAST  = 1;
  localparam int DECAY_SLOW  = 2;

  // Cycle budget per test, the watchdog allows twice the sum
  localparam int RESET_CYCLES    = 2 * 16;
  localparam int STEP_CYCLES     = 4 + 40 * 8;
  localparam int POLARITY_CYCLES = 256 * 6;
  localparam int DECAY_CYCLES    = OFF_TICKS + BLANK_TICKS + 8;
  localparam int FAULT_CYCLES    = 6 + 28 + 10 + 100 + 17;
  localparam int ENABLE_CYCLES   = 8 + 12 * 6 + 1;
  localparam int TOTAL_CYCLES    = RESET_CYCLES + STEP_CYCLES + POLARITY_CYCLES +
                                   DECAY_CYCLES + FAULT_CYCLES + ENABLE_CYCLES;

  logic clk;
  logic resetn;
  logic step;
  logic dir;
  logic enable_in;
  logic analog_cmp_a;
  logic analog_cmp_b;
  logic config_invert_highside;
  logic config_invert_lowside;
  logic faultn;
  logic phase_a1_h, phase_a1_l, phase_a2_h, phase_a2_l;
  logic phase_b1_h, phase_b1_l, phase_b2_h, phase_b2_l;

  bridge_pkg::off_count_t config_fastdecay_threshold;
  motion_pkg::phase_t     phase_ct;
  motion_pkg::phase_t     model_phase;

  // Gate pins in order a1, a2, b1, b2, high side above low side
  logic [7:0] gates;

  int    seed;
  int    pass_count;
  int    fail_count;
  int    fails_before;
  string test_name;

  assign gates = {phase_a1_h, phase_a1_l, phase_a2_h, phase_a2_l,
                  phase_b1_h, phase_b1_l, phase_b2_h, phase_b2_l};

  microstepper_top #(.OFF_TICKS(OFF_TICKS)) dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(2 * TOTAL_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not complete", 2 * TOTAL_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  // Without inversion a high side and its low side are never on together
  no_shoot_through: assert property (
    @(posedge clk) disable iff (!resetn)
    (!config_invert_highside && !config_invert_lowside) |->
      (gates[7:6] != 2'b11) && (gates[5:4] != 2'b11) &&
      (gates[3:2] != 2'b11) && (gates[1:0] != 2'b11)
  ) else begin
    fail_count++;
    $display("%s: a high side and its low side were on at the same time", test_name);
  end

  // One half-bridge as {high, low}
  function automatic logic [1:0] half_bridge(input logic pol, input int decay, input logic off);
    logic [1:0] hl;
    if (off || decay == DECAY_SLOW) begin
      hl = 2'b01;
    end else if (decay == DECAY_FAST) begin
      hl = {~pol, pol};
    end else begin
      hl = {pol, ~pol};
    end
    return hl;
  endfunction

  function automatic logic [7:0] expected_gates(input logic [7:0] phase, input int decay_a,
                                                input int decay_b, input logic off,
                                                input logic inv_h, input logic inv_l);
    logic       pol_a;
    logic       pol_b;
    logic [7:0] g;
    pol_a = (phase[7:6] == 2'd0) || (phase[7:6] == 2'd3);
    pol_b = (phase[7:6] == 2'd0) || (phase[7:6] == 2'd1);
    g = {half_bridge(pol_a, decay_a, off), half_bridge(~pol_a, decay_a, off),
         half_bridge(pol_b, decay_b, off), half_bridge(~pol_b, decay_b, off)};
    return g ^ {4{inv_h, inv_l}};
  endfunction

  task automatic check_value(input string what, input logic [7:0] expected,
                             input logic [7:0] actual);
    assert (actual === expected) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("error %s %s: expected 'h%0h, actual 'h%0h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    assert (ok === 1'b1) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("%s: %s", test_name, what);
    end
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic apply_step(input logic direction, input int high_cycles, input int low_cycles);
    dir  = direction;
    step = 1'b1;
    repeat (high_cycles) @(negedge clk);
    step = 1'b0;
    repeat (low_cycles) @(negedge clk);
    model_phase = direction ? model_phase + 8'd1 : model_phase - 8'd1;
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    fails_before = fail_count;
  endtask

  task automatic end_test();
    $display("%s: %s, %0d errors", test_name,
             (fail_count == fails_before) ? "pass" : "fail", fail_count - fails_before);
  endtask

  initial begin
    logic [7:0] normal;
    logic [7:0] fast_pat;
    logic [7:0] slow_pat;
    logic [3:0] a_bits;
    logic       dir_bit;
    int         stage;
    int         fast_n;
    int         slow_n;
    int         n;

    seed         = 66025;
    pass_count   = 0;
    fail_count   = 0;
    fails_before = 0;
    test_name    = "reset";
    model_phase  = '0;
    resetn       = 1'b0;
    step         = 1'b0;
    dir          = 1'b0;
    enable_in    = 1'b0;
    analog_cmp_a = 1'b0;
    analog_cmp_b = 1'b0;
    config_fastdecay_threshold = bridge_pkg::off_count_t'(THRESHOLD);
    config_invert_highside     = 1'b0;
    config_invert_lowside      = 1'b0;
    repeat (16) @(negedge clk);
    resetn = 1'b1;

    start_test("step_count");
    enable_in = 1'b1;
    repeat (4) @(negedge clk);
    for (n = 0; n < 40; n++) begin
      dir_bit = 1'($random(seed));
      apply_step(dir_bit, 4, 4);
      check_value("phase_ct", model_phase, phase_ct);
    end
    end_test();

    // A full turn of the counter visits every quadrant
    start_test("polarity");
    for (n = 0; n < 256; n++) begin
      apply_step(1'b1, 3, 3);
      check_value("gates", expected_gates(model_phase, DECAY_NONE, DECAY_NONE, 1'b0,
                                          1'b0, 1'b0), gates);
    end
    end_test();

    start_test("decay");
    normal   = expected_gates(model_phase, DECAY_NONE, DECAY_NONE, 1'b0, 1'b0, 1'b0);
    fast_pat = expected_gates(model_phase, DECAY_FAST, DECAY_NONE, 1'b0, 1'b0, 1'b0);
    slow_pat = expected_gates(model_phase, DECAY_SLOW, DECAY_NONE, 1'b0, 1'b0, 1'b0);
    stage  = 0;
    fast_n = 0;
    slow_n = 0;
    analog_cmp_a = 1'b1;
    for (n = 0; n < OFF_TICKS + BLANK_TICKS + 4 && stage != 3; n++) begin
      @(negedge clk);
      // Peak is registered by now, drop it so only one off-time follows
      if (n == 2) begin
        analog_cmp_a = 1'b0;
      end
      a_bits = gates[7:4];
      check_value("winding B", normal[3:0], gates[3:0]);
      case (stage)
        0: begin
          if (a_bits == fast_pat[7:4]) begin
            stage = 1;
          end else begin
            check_true(a_bits == normal[7:4], "winding A left normal drive without fast decay");
          end
        end
        1: begin
          if (a_bits == slow_pat[7:4]) begin
            stage = 2;
          end else begin
            check_true(a_bits == fast_pat[7:4], "winding A left fast decay without slow decay");
          end
        end
        default: begin
          if (a_bits == normal[7:4]) begin
            stage = 3;
          end else begin
            check_true(a_bits == slow_pat[7:4], "winding A left slow decay for a wrong pattern");
          end
        end
      endcase
      if (stage == 1) fast_n++;
      if (stage == 2) slow_n++;
    end
    check_true(stage == 3, "winding A did not return to normal drive in time");
    check_value("fast decay cycles", OFF_TICKS - THRESHOLD + 1, fast_n);
    check_value("slow decay cycles", THRESHOLD - 1, slow_n);
    end_test();

    // Restart the choppers so winding B is inside its minimum on-time
    start_test("fault");
    enable_in = 1'b0;
    repeat (6) @(negedge clk);
    enable_in = 1'b1;
    repeat (28) @(negedge clk);
    analog_cmp_b = 1'b1;
    n = 0;
    while (faultn !== 1'b0 && n < 10) begin
      @(negedge clk);
      n++;
    end
    analog_cmp_b = 1'b0;
    check_true(faultn === 1'b0, "faultn did not fall after an early current peak");
    for (n = 0; n < 100; n++) begin
      @(negedge clk);
      check_value("faultn", 8'd0, faultn);
      check_value("gates", expected_gates(model_phase, DECAY_NONE, DECAY_NONE, 1'b1,
                                          1'b0, 1'b0), gates);
    end
    resetn    = 1'b0;
    enable_in = 1'b0;
    repeat (16) @(negedge clk);
    resetn      = 1'b1;
    model_phase = '0;
    @(negedge clk);
    check_value("faultn after reset", 8'd1, faultn);
    end_test();

    start_test("enable_invert");
    repeat (2) @(negedge clk);
    normal = expected_gates(model_phase, DECAY_NONE, DECAY_NONE, 1'b1, 1'b0, 1'b0);
    check_value("gates disabled", normal, gates);
    config_invert_highside = 1'b1;
    config_invert_lowside  = 1'b1;
    @(negedge clk);
    check_value("gates disabled inverted", ~normal, gates);
    enable_in = 1'b1;
    repeat (4) @(negedge clk);
    normal = expected_gates(model_phase, DECAY_NONE, DECAY_NONE, 1'b0, 1'b0, 1'b0);
    check_value("gates enabled inverted", ~normal, gates);
    for (n = 0; n < 12; n++) begin
      dir_bit = 1'($random(seed));
      apply_step(dir_bit, 3, 3);
      normal = expected_gates(model_phase, DECAY_NONE, DECAY_NONE, 1'b0, 1'b0, 1'b0);
      check_value("gates stepping inverted", ~normal, gates);
    end
    config_invert_highside = 1'b0;
    config_invert_lowside  = 1'b0;
    @(negedge clk);
    check_value("gates inversion cleared", normal, gates);
    end_test();

    $display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
hw/motion_pkg.sv
hw/bridge_pkg.sv
hw/stepper_ifs.sv
hw/step_dir_decode.sv
hw/chopper_timer.sv
hw/bridge_driver.sv
hw/microstepper_top.sv
sim/tb_microstepper.sv

//--- Bender.yml
package:
  name: microstepper

sources:
  - hw/motion_pkg.sv
  - hw/bridge_pkg.sv
  - hw/stepper_ifs.sv
  - hw/step_dir_decode.sv
  - hw/chopper_timer.sv
  - hw/bridge_driver.sv
  - hw/microstepper_top.sv
  - target: simulation
    files:
      - sim/tb_microstepper.sv
